//--- hdl/bank_scheduler.sv
`timescale 1ns/100ps
`default_nettype none

module bank_scheduler import memctl_pkg::*; #(
   parameter int BANK_ID  = 0,  // {bg, ba} served here
   parameter int RD_DEPTH = 4,  // Read queue slots
   parameter int WR_DEPTH = 4,  // Write queue slots, at most WR_DEPTH_MAX
   parameter int RA_POS   = 0   // Bank bits position in ra
) (
   input  wire logic  clk,
   input  wire logic  rst_i,
   input  wire req_t  head_i,        // Request FIFO head
   input  wire logic  head_valid_i,  // Head holds a request
   input  wire mode_e mode_i,        // Global bus direction
   input  wire logic  ready_i,       // Arbiter picked this bank
   output      logic  grant_o,       // Head accepted into a queue
   output      logic  valid_o,       // Command available
   output      cmd_t  cmd_o,         // Oldest entry of the selected queue
   output      logic  rd_empty_o,    // No read pending
   output      cnt_t  wr_cnt_o       // Writes pending
);

   localparam int RD_AW = (RD_DEPTH > 1) ? $clog2(RD_DEPTH) : 1;
   localparam int WR_AW = (WR_DEPTH > 1) ? $clog2(WR_DEPTH) : 1;
   localparam int RD_CW = $clog2(RD_DEPTH + 1);

   req_t             rd_mem [RD_DEPTH];  // Read queue storage
   req_t             wr_mem [WR_DEPTH];  // Write queue storage
   logic [RD_AW-1:0] rd_wptr;
   logic [RD_AW-1:0] rd_rptr;
   logic [WR_AW-1:0] wr_wptr;
   logic [WR_AW-1:0] wr_rptr;
   logic [RD_CW-1:0] rd_cnt;            // Read occupancy
   cnt_t             wr_cnt;            // Write occupancy
   logic [1:0]       head_bank;         // {bg, ba} of the FIFO head
   logic             bank_hit;
   logic             rd_push;
   logic             wr_push;
   logic             rd_pop;
   logic             wr_pop;

   // Bank decode, upper bit is bank group
   assign head_bank = head_i.ra[RA_POS +: 2];
   assign bank_hit  = head_valid_i && (head_bank == 2'(BANK_ID));

   // Accept only when the queue for this type has a free slot
   assign rd_push = bank_hit && (head_i.t == MODE_READ) && (rd_cnt != RD_CW'(RD_DEPTH));
   assign wr_push = bank_hit && (head_i.t == MODE_WRITE) && (wr_cnt != cnt_t'(WR_DEPTH));
   assign grant_o = rd_push || wr_push;  // FIFO pops on the next edge

   // Mode picks which queue faces the arbiter
   assign valid_o = (mode_i == MODE_READ) ? (rd_cnt != '0) : (wr_cnt != '0);
   assign rd_pop  = ready_i && valid_o && (mode_i == MODE_READ);
   assign wr_pop  = ready_i && valid_o && (mode_i == MODE_WRITE);

   assign cmd_o.req = (mode_i == MODE_READ) ? rd_mem[rd_rptr] : wr_mem[wr_rptr];
   assign cmd_o.bg  = 1'(BANK_ID >> 1);  // Fixed per instance
   assign cmd_o.ba  = 1'(BANK_ID);

   assign rd_empty_o = (rd_cnt == '0);
   assign wr_cnt_o   = wr_cnt;

   always_ff @(posedge clk) begin
      if (rd_push) begin
         rd_mem[rd_wptr] <= head_i;
      end
      if (wr_push) begin
         wr_mem[wr_wptr] <= head_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         rd_wptr <= '0;
         rd_rptr <= '0;
         wr_wptr <= '0;
         wr_rptr <= '0;
         rd_cnt  <= '0;
         wr_cnt  <= '0;
      end else begin
         if (rd_push) begin
            rd_wptr <= (rd_wptr == RD_AW'(RD_DEPTH - 1)) ? '0 : rd_wptr + 1'b1;
         end
         if (rd_pop) begin
            rd_rptr <= (rd_rptr == RD_AW'(RD_DEPTH - 1)) ? '0 : rd_rptr + 1'b1;
         end
         if (wr_push) begin
            wr_wptr <= (wr_wptr == WR_AW'(WR_DEPTH - 1)) ? '0 : wr_wptr + 1'b1;
         end
         if (wr_pop) begin
            wr_rptr <= (wr_rptr == WR_AW'(WR_DEPTH - 1)) ? '0 : wr_rptr + 1'b1;
         end
         rd_cnt <= rd_cnt + RD_CW'(rd_push) - RD_CW'(rd_pop);  // Fill and drain together
         wr_cnt <= wr_cnt + cnt_t'(wr_push) - cnt_t'(wr_pop);
      end
   end

endmodule

`default_nettype wire

//--- hdl/cmd_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module cmd_arbiter import memctl_pkg::*; (
   input  wire logic      clk,
   input  wire logic      rst_i,
   input  wire bank_vec_t valid_i,             // Banks with a command
   input  wire cmd_t      cmd_i [NUM_BANKS],    // Per-bank candidate
   output      bank_vec_t ready_o,             // One-hot pop to the winner
   output      logic      cmd_valid_o,         // Bus command strobe
   output      cmd_t      cmd_o                // Registered winner
);

   localparam int BW = $clog2(NUM_BANKS);  // Bank index width

   logic [BW-1:0] last_q;  // Previous winner
   logic [BW-1:0] win;     // Bank picked this cycle
   logic          found;   // Some bank was valid

   // Search starts one past the last winner
   always_comb begin
      int cand;
      win   = last_q;
      found = 1'b0;
      for (int i = 1; i <= NUM_BANKS; i++) begin
         cand = (int'(last_q) + i) % NUM_BANKS;
         if (!found && valid_i[cand]) begin
            win   = BW'(cand);  // First hit wins
            found = 1'b1;
         end
      end
   end

   assign ready_o = found ? (bank_vec_t'(1) << win) : '0;  // Bank pops on this edge

   always_ff @(posedge clk) begin
      if (rst_i) begin
         cmd_valid_o <= 1'b0;
         last_q      <= BW'(NUM_BANKS - 1);  // Bank 0 has priority first
      end else begin
         cmd_valid_o <= found;
         if (found) begin
            last_q <= win;  // Rotate priority past the winner
         end
      end
   end

   // Payload follows the strobe, no clear needed
   always_ff @(posedge clk) begin
      if (found) begin
         cmd_o <= cmd_i[win];
      end
   end

endmodule

`default_nettype wire

//--- hdl/memctl_pkg.sv
`default_nettype none

package memctl_pkg;

   // Field widths of one host request
   localparam int DQ_W  = 16;  // Write data
   localparam int IDX_W = 6;   // Transaction index
   localparam int RA_W  = 16;  // Row address
   localparam int CA_W  = 10;  // Column address

   localparam int NUM_BANKS = 4;  // One bg bit times one ba bit

   // Write counters are sized for the deepest write queue supported
   localparam int WR_DEPTH_MAX = 15;                      // Upper bound on WR_DEPTH
   localparam int CNT_W        = $clog2(WR_DEPTH_MAX + 1);  // Bits per bank write count

   // Bus direction, also used as the request type
   typedef enum logic {
      MODE_READ  = 1'b0,
      MODE_WRITE = 1'b1
   } mode_e;

   // One host request, 49 bits
   typedef struct packed {
      logic [DQ_W-1:0]  dq;   // Write data, don't care for reads
      mode_e            t;    // Read or write
      logic [IDX_W-1:0] idx;  // Host transaction tag
      logic [RA_W-1:0]  ra;   // Row, holds bank bits at RA_POS
      logic [CA_W-1:0]  ca;   // Column
   } req_t;

   // One command on the memory bus, 51 bits
   typedef struct packed {
      req_t req;  // Request as queued
      logic bg;   // Bank group
      logic ba;   // Bank address
   } cmd_t;

   typedef logic [NUM_BANKS-1:0] bank_vec_t;  // One bit per bank
   typedef logic [CNT_W-1:0]     cnt_t;       // Per-bank write occupancy

endpackage

`default_nettype wire

//--- hdl/memctl_top.sv
`timescale 1ns/100ps
`default_nettype none

module memctl_top import memctl_pkg::*; #(
   parameter int FIFO_DEPTH = 8,  // Host request FIFO slots
   parameter int RD_DEPTH   = 4,  // Per-bank read queue
   parameter int WR_DEPTH   = 4,  // Per-bank write queue
   parameter int RA_POS     = 0,  // Bank bits in ra, at most RA_W-2
   parameter int WR_HIGH    = 6,  // Write mode entry level
   parameter int WR_LOW     = 2   // Write mode exit level
) (
   input  wire logic  clk,
   input  wire logic  rst_i,
   input  wire logic  req_valid_i,  // Host push strobe
   input  wire req_t  req_i,        // Host request
   output      logic  req_full_o,   // Host must hold off
   output      logic  cmd_valid_o,  // Memory bus strobe
   output      cmd_t  cmd_o,        // Memory bus command
   output      mode_e mode_o        // Current bus direction
);

   req_t      fifo_head;               // Broadcast to all banks
   logic      fifo_valid;
   bank_vec_t sched_grant;             // Bank that took the head
   bank_vec_t rd_empty;
   cnt_t      wr_cnt [NUM_BANKS];
   mode_e     mode;
   bank_vec_t sched_valid;
   cmd_t      sched_cmd [NUM_BANKS];
   bank_vec_t arb_ready;               // One-hot pop from the arbiter

   assign mode_o = mode;

   req_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
      .clk(clk), .rst_i(rst_i),
      .push_i(req_valid_i), .push_data_i(req_i), .grant_i(sched_grant),
      .head_o(fifo_head), .valid_o(fifo_valid), .full_o(req_full_o)
   );

   for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      bank_scheduler #(
         .BANK_ID(b), .RD_DEPTH(RD_DEPTH), .WR_DEPTH(WR_DEPTH), .RA_POS(RA_POS)
      ) u_sched (
         .clk(clk), .rst_i(rst_i),
         .head_i(fifo_head), .head_valid_i(fifo_valid), .mode_i(mode),
         .ready_i(arb_ready[b]), .grant_o(sched_grant[b]), .valid_o(sched_valid[b]),
         .cmd_o(sched_cmd[b]), .rd_empty_o(rd_empty[b]), .wr_cnt_o(wr_cnt[b])
      );
   end

   mode_ctrl #(.WR_HIGH(WR_HIGH), .WR_LOW(WR_LOW)) u_mode (
      .clk(clk), .rst_i(rst_i),
      .rd_empty_i(rd_empty), .wr_cnt_i(wr_cnt), .mode_o(mode)
   );

   cmd_arbiter u_arb (
      .clk(clk), .rst_i(rst_i),
      .valid_i(sched_valid), .cmd_i(sched_cmd), .ready_o(arb_ready),
      .cmd_valid_o(cmd_valid_o), .cmd_o(cmd_o)
   );

endmodule

`default_nettype wire

//--- hdl/mode_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module mode_ctrl import memctl_pkg::*; #(
   parameter int WR_HIGH = 6,  // Enter write mode at this many writes
   parameter int WR_LOW  = 2   // Leave write mode at or below this
) (
   input  wire logic      clk,
   input  wire logic      rst_i,
   input  wire bank_vec_t rd_empty_i,           // Per-bank read queue empty
   input  wire cnt_t      wr_cnt_i [NUM_BANKS],  // Per-bank write occupancy
   output      mode_e     mode_o                // Registered bus direction
);

   localparam int TOT_W = $clog2(NUM_BANKS * WR_DEPTH_MAX + 1);  // Fits the sum of all banks

   logic [TOT_W-1:0] wr_total;      // Writes pending over all banks
   logic             all_rd_empty;  // Nothing to read anywhere
   mode_e            mode_nxt;

   always_comb begin
      wr_total = '0;
      for (int b = 0; b < NUM_BANKS; b++) begin
         wr_total = wr_total + TOT_W'(wr_cnt_i[b]);
      end
   end

   assign all_rd_empty = &rd_empty_i;

   // Hysteresis band between WR_LOW and WR_HIGH keeps the bus from flipping
   always_comb begin
      mode_nxt = mode_o;
      case (mode_o)
         MODE_READ: begin
            if ((wr_total >= WR_HIGH) || (all_rd_empty && (wr_total != '0))) begin
               mode_nxt = MODE_WRITE;  // Writes piled up or reads idle
            end
         end
         MODE_WRITE: begin
            if ((wr_total == '0) || ((wr_total <= WR_LOW) && !all_rd_empty)) begin
               mode_nxt = MODE_READ;  // Drained, or reads waiting
            end
         end
         default: mode_nxt = MODE_READ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         mode_o <= MODE_READ;
      end else begin
         mode_o <= mode_nxt;
      end
   end

endmodule

`default_nettype wire

//--- hdl/req_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module req_fifo import memctl_pkg::*; #(
   parameter int DEPTH = 8  // Request slots
) (
   input  wire logic      clk,
   input  wire logic      rst_i,
   input  wire logic      push_i,       // Host write strobe
   input  wire req_t      push_data_i,  // Incoming request
   input  wire bank_vec_t grant_i,      // At most one bank takes the head
   output      req_t      head_o,       // Oldest stored request
   output      logic      valid_o,      // Head is meaningful
   output      logic      full_o        // No free slot left
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width
   localparam int CW = $clog2(DEPTH + 1);               // Occupancy width

   req_t          mem [DEPTH];  // Request storage
   logic [AW-1:0] wr_ptr;       // Next free slot
   logic [AW-1:0] rd_ptr;       // Current head
   logic [CW-1:0] count;        // Stored entries
   logic          push;
   logic          pop;

   assign push    = push_i && !full_o;  // Push while full is dropped
   assign pop     = |grant_i;          // Grant only comes with a valid head
   assign head_o  = mem[rd_ptr];
   assign valid_o = (count != '0);
   assign full_o  = (count == CW'(DEPTH));

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= push_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at DEPTH
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count <= count + CW'(push) - CW'(pop);  // Push and pop may coincide
      end
   end

endmodule

`default_nettype wire

//--- memctl.f
hdl/memctl_pkg.sv
hdl/req_fifo.sv
hdl/bank_scheduler.sv
hdl/mode_ctrl.sv
hdl/cmd_arbiter.sv
hdl/memctl_top.sv
testbench/memctl_props.sv
testbench/memctl_tb.sv

//--- testbench/memctl_props.sv
`timescale 1ns/100ps
`default_nettype none

module memctl_props import memctl_pkg::*; #(
   parameter int WR_HIGH = 6,  // Same levels as the mode controller
   parameter int WR_LOW  = 2
) (
   input  wire logic        clk,
   input  wire logic        rst_i,
   input  wire bank_vec_t   valid_i,     // Arbiter request vector
   input  wire bank_vec_t   ready_i,     // Arbiter grant vector
   input  wire mode_e       mode_i,      // Registered bus direction
   input  wire logic [31:0] wr_total_i   // Writes pending over all banks
);

   int unsigned fail_cnt = 0;  // Read by the testbench monitor

   a_ready_onehot: assert property (@(posedge clk) disable iff (rst_i) $onehot0(ready_i))
      else begin
         $error("ready not one-hot");
         fail_cnt++;
      end

   a_ready_valid: assert property (@(posedge clk) disable iff (rst_i)
      (ready_i & ~valid_i) == '0)
      else begin
         $error("ready without valid");
         fail_cnt++;
      end

   // Inside the hysteresis band a fresh switch must hold for the next cycle
   a_mode_hold: assert property (@(posedge clk) disable iff (rst_i)
      (mode_i != $past(mode_i)) && (wr_total_i > WR_LOW) && (wr_total_i < WR_HIGH)
      |=> (mode_i == $past(mode_i)))
      else begin
         $error("mode flipped twice inside band");
         fail_cnt++;
      end

endmodule

bind cmd_arbiter memctl_props arb_props (
   .clk(clk), .rst_i(rst_i), .valid_i(valid_i), .ready_i(ready_o),
   .mode_i(MODE_READ), .wr_total_i(32'd0)  // Mode checks idle here
);

bind mode_ctrl memctl_props #(.WR_HIGH(WR_HIGH), .WR_LOW(WR_LOW)) mode_props (
   .clk(clk), .rst_i(rst_i), .valid_i('0), .ready_i('0),
   .mode_i(mode_o), .wr_total_i(32'(wr_total))  // Internal sum of the controller
);

`default_nettype wire

//--- testbench/memctl_tb.sv
`timescale 1ns/100ps
`default_nettype none

module memctl_tb import memctl_pkg::*;;

   localparam int RA_POS      = 0;
   localparam int STIM_CYCLES = 600;   // Cycles of random traffic
   localparam int DRAIN_MAX   = 2000;  // Drain timeout in cycles

   logic  clk = 1'b0;
   logic  rst_i;
   logic  req_valid_i;
   req_t  req_i;
   logic  req_full_o;
   logic  cmd_valid_o;
   cmd_t  cmd_o;
   mode_e mode_o;

   logic  stim_on;               // Random traffic enabled
   int    idx_cnt = 0;           // Accepted host requests
   mode_e prev_mode = MODE_READ; // mode_o one cycle back
   req_t  model_q [NUM_BANKS*2][$];  // Index bank*2+type

   memctl_top #(
      .FIFO_DEPTH(8), .RD_DEPTH(4), .WR_DEPTH(4), .RA_POS(RA_POS), .WR_HIGH(6), .WR_LOW(2)
   ) dut_i (
      .clk(clk), .rst_i(rst_i), .req_valid_i(req_valid_i), .req_i(req_i),
      .req_full_o(req_full_o), .cmd_valid_o(cmd_valid_o), .cmd_o(cmd_o), .mode_o(mode_o)
   );

   always #20 clk = ~clk;  // 40 ns period

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic check_cmd(string name, cmd_t got, cmd_t exp_v);
      if (got !== exp_v) begin
         $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp_v);
         abort_run();
      end
   endtask

   task automatic check_mode(string name, mode_e got, mode_e exp_v);
      if (got !== exp_v) begin
         $display("[FAIL] t=%0t %s got=%s exp=%s", $time, name, got.name(), exp_v.name());
         abort_run();
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp_v);
      if (got !== exp_v) begin
         $display("[FAIL] t=%0t %s got=%b exp=%b", $time, name, got, exp_v);
         abort_run();
      end
   endtask

   function automatic bit all_empty();
      for (int k = 0; k < NUM_BANKS*2; k++) begin
         if (model_q[k].size() != 0) return 1'b0;
      end
      return 1'b1;
   endfunction

   // Record accepted pushes, then drive the next request
   always @(posedge clk) begin : driver
      req_t       r;
      logic [1:0] bank;
      if (!rst_i) begin
         if (req_valid_i && !req_full_o) begin   // DUT takes it on this edge
            bank = req_i.ra[RA_POS +: 2];         // bg is the upper bit
            model_q[int'(bank)*2 + int'(req_i.t)].push_back(req_i);
            idx_cnt++;
         end
         if (stim_on && !req_full_o) begin
            r.dq  = DQ_W'($urandom);
            r.t   = mode_e'($urandom_range(0, 1));
            r.idx = IDX_W'(idx_cnt);
            r.ra  = RA_W'($urandom);
            r.ra[RA_POS +: 2] = 2'($urandom_range(0, 3));  // Target bank
            r.ca  = CA_W'($urandom);
            req_i       <= r;
            req_valid_i <= ($urandom_range(0, 3) != 0);  // Busy host, 3 of 4 cycles
         end else begin
            req_valid_i <= 1'b0;
         end
      end
   end

   // Outputs are stable at the falling edge
   always @(negedge clk) begin : monitor
      int   key;
      cmd_t exp_cmd;
      if (!rst_i) begin
         if (dut_i.u_arb.arb_props.fail_cnt + dut_i.u_mode.mode_props.fail_cnt != 0) begin
            $display("A bound assertion on the arbiter or mode controller failed at %0t", $time);
            abort_run();
         end
         if (cmd_valid_o) begin
            key = int'({cmd_o.bg, cmd_o.ba})*2 + int'(cmd_o.req.t);
            if (model_q[key].size() == 0) begin
               $display("Command at %0t for bank %0d with nothing pending of that type",
                        $time, int'({cmd_o.bg, cmd_o.ba}));
               abort_run();
            end
            exp_cmd.req = model_q[key].pop_front();          // Oldest of bank and type
            exp_cmd.bg  = exp_cmd.req.ra[RA_POS + 1];
            exp_cmd.ba  = exp_cmd.req.ra[RA_POS];
            check_mode("cmd_o.req.t", cmd_o.req.t, prev_mode);  // Direction of last cycle
            check_cmd("cmd_o", cmd_o, exp_cmd);
         end
      end
      prev_mode = mode_o;
   end

   initial begin
      int unsigned seed_r;
      bit          done;
      seed_r      = $urandom(32'h6964110b);
      rst_i       = 1'b1;
      req_valid_i = 1'b0;
      req_i       = '0;
      stim_on     = 1'b0;
      repeat (8) @(posedge clk);
      rst_i <= 1'b0;
      @(negedge clk);
      check_bit("cmd_valid_o", cmd_valid_o, 1'b0);  // Idle state out of reset
      check_bit("req_full_o", req_full_o, 1'b0);
      check_mode("mode_o", mode_o, MODE_READ);
      @(posedge clk);
      stim_on <= 1'b1;
      repeat (STIM_CYCLES) @(posedge clk);
      stim_on <= 1'b0;
      done = 1'b0;
      for (int c = 0; c < DRAIN_MAX && !done; c++) begin
         @(posedge clk);
         done = all_empty() && !req_valid_i;  // Pops of the last negedge are in, no push now
      end
      if (!done) begin
         $display("Timeout: requests still pending after %0d drain cycles", DRAIN_MAX);
         abort_run();
      end
      @(negedge clk);  // Bus idle once the queues are drained
      for (int c = 0; c < 16 && mode_o != MODE_READ; c++) begin
         @(negedge clk);  // Mode register trails the last write pop
      end
      check_mode("mode_o", mode_o, MODE_READ);
      check_bit("cmd_valid_o", cmd_valid_o, 1'b0);
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire
